/* Makefile */
# Verilator build for the data cache testbench
VERILATOR ?= verilator
TOP       ?= tb_dcache
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
EXTRA     ?=

SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# the simulator exits non-zero on $fatal, so make fails with it
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* flist.f */
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_tags.sv
logic/dcache_data.sv
logic/dcache_ctrl.sv
logic/wb_master.sv
logic/dcache_top.sv
test/tb_wb_memory.sv
test/tb_dcache.sv

/* logic/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

`define DC_SETS 16       // sets per way
`define DC_IDX_W 4       // index bits, log2 of DC_SETS
`define DC_TAG_W 25      // what is left of a 32-bit address after idx, blkoff and byteoff

//////////////////////////////////////////////////
// fixed addresses and memory size
//////////////////////////////////////////////////

`define DC_COUNTER_ADDR 32'h3100   // hit count lands here at the end of a flush
`define DC_MEM_WORDS 4096

`endif

/* logic/dcache_ctrl.sv */
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                    CLK,
    input  logic                    n_rst,
    input  logic                    halt,
    input  dcache_pkg::cpu_req_t    req,
    output dcache_pkg::cpu_rsp_t    rsp,
    output logic                    done,
    output dcache_pkg::mem_req_t    mem_req,
    input  dcache_pkg::mem_rsp_t    mem_rsp,
    output logic [`DC_IDX_W-1:0]    idx,
    output logic [`DC_TAG_W-1:0]    tag,
    output logic                    touch,
    output logic                    touch_way,
    output logic                    fill,
    output logic                    fill_way,
    output logic                    set_dirty,
    output logic                    clear_dirty,
    output logic                    inv_all,
    input  logic                    hit_way0,
    input  logic                    hit_way1,
    input  logic                    victim_way,
    input  logic                    victim_dirty,
    input  logic [`DC_TAG_W-1:0]    victim_tag,
    output logic [`DC_IDX_W-1:0]    scan_idx,
    input  logic                    scan_dirty0,
    input  logic                    scan_dirty1,
    input  logic [`DC_TAG_W-1:0]    scan_tag0,
    input  logic [`DC_TAG_W-1:0]    scan_tag1,
    output logic [`DC_IDX_W-1:0]    rd_idx,
    input  dcache_pkg::word_t [1:0] rd_words0,
    input  dcache_pkg::word_t [1:0] rd_words1,
    output logic                    we,
    output logic                    we_way,
    output logic                    we_blkoff,
    output logic [`DC_IDX_W-1:0]    we_idx,
    output dcache_pkg::word_t       wdata
);

    typedef enum logic [3:0] {
        IDLE, WB0, WB1, FILL0, FILL1, COMPLETE, FLUSH, COUNT_WR, DONE_ST
    } state_t;

    state_t                 state, next_state;
    logic [`DC_IDX_W:0]     scan, next_scan;   // {set, way} position of the flush walk
    logic                   flush_q;
    dcache_pkg::word_t      hit_count, next_hit_count;
    dcache_pkg::dc_addr_t   a;
    dcache_pkg::dc_frame_t  wb_frame;
    logic                   scan_way, any_hit, blk_sel;

    function automatic dcache_pkg::word_t blk_addr(input logic [`DC_TAG_W-1:0] t,
                                                   input logic [`DC_IDX_W-1:0] i,
                                                   input logic b);
        dcache_pkg::dc_addr_t ba;
        ba = '{tag: t, idx: i, blkoff: b, byteoff: 2'b00};
        return dcache_pkg::word_t'(ba);
    endfunction

    assign a        = dcache_pkg::dc_addr_t'(req.addr);
    assign idx      = a.idx;
    assign tag      = a.tag;
    assign we_idx   = a.idx;
    assign scan_idx = scan[`DC_IDX_W:1];
    assign scan_way = scan[0];
    assign rd_idx   = flush_q ? scan_idx : a.idx;
    assign any_hit  = (req.rd || req.wr) && (hit_way0 || hit_way1);
    assign blk_sel  = (state == WB1) || (state == FILL1);
    assign done     = (state == DONE_ST);

    // block that goes out on a write-back, the miss victim or the frame under the flush scan
    always_comb begin
        wb_frame.valid = 1'b1;   // only dirty frames leave, and dirty implies valid
        if (flush_q) begin
            wb_frame.dirty = scan_way ? scan_dirty1 : scan_dirty0;
            wb_frame.tag   = scan_way ? scan_tag1 : scan_tag0;
            wb_frame.data  = scan_way ? rd_words1 : rd_words0;
        end else begin
            wb_frame.dirty = victim_dirty;
            wb_frame.tag   = victim_tag;
            wb_frame.data  = victim_way ? rd_words1 : rd_words0;
        end
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state     <= IDLE;
            scan      <= '0;
            flush_q   <= 1'b0;
            hit_count <= '0;
        end else begin
            state     <= next_state;
            scan      <= next_scan;
            hit_count <= next_hit_count;
            if (state == IDLE && halt)
                flush_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////

    always_comb begin
        next_state     = state;
        next_scan      = scan;
        next_hit_count = hit_count;
        rsp            = '0;
        mem_req        = '0;
        touch          = 1'b0;
        touch_way      = victim_way;
        fill           = 1'b0;
        fill_way       = victim_way;
        set_dirty      = 1'b0;
        clear_dirty    = 1'b0;
        inv_all        = 1'b0;
        we             = 1'b0;
        we_way         = victim_way;
        we_blkoff      = a.blkoff;
        wdata          = req.wdata;

        case (state)
            IDLE: begin
                if (halt) begin
                    next_scan  = '0;
                    next_state = FLUSH;
                end else if (any_hit) begin
                    // every hit seen here is a first try, retries finish in COMPLETE
                    rsp.hit        = 1'b1;
                    rsp.rdata      = hit_way1 ? rd_words1[a.blkoff] : rd_words0[a.blkoff];
                    touch          = 1'b1;
                    touch_way      = hit_way1;
                    we             = req.wr;
                    we_way         = hit_way1;
                    set_dirty      = req.wr;
                    next_hit_count = hit_count + 1'b1;
                end else if (req.rd || req.wr) begin
                    next_state = wb_frame.dirty ? WB0 : FILL0;
                end
            end
            WB0, WB1: begin
                mem_req.valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = blk_addr(wb_frame.tag, rd_idx, blk_sel);
                mem_req.wdata = wb_frame.data[blk_sel];
                if (mem_rsp.done) begin
                    if (state == WB0) begin
                        next_state = WB1;
                    end else if (flush_q) begin
                        clear_dirty = 1'b1;        // scan sees a clean frame and moves on
                        fill_way    = scan_way;
                        next_state  = FLUSH;
                    end else begin
                        next_state = FILL0;
                    end
                end
            end
            FILL0, FILL1: begin
                mem_req.valid = 1'b1;
                mem_req.addr  = blk_addr(a.tag, a.idx, blk_sel);
                if (mem_rsp.done) begin
                    we         = 1'b1;
                    we_blkoff  = blk_sel;
                    wdata      = mem_rsp.rdata;
                    fill       = (state == FILL1);
                    next_state = (state == FILL0) ? FILL1 : COMPLETE;
                end
            end
            COMPLETE: begin
                rsp.hit    = 1'b1;
                rsp.rdata  = victim_way ? rd_words1[a.blkoff] : rd_words0[a.blkoff];
                touch      = 1'b1;
                we         = req.wr;
                set_dirty  = req.wr;
                next_state = IDLE;
            end
            FLUSH: begin
                if (wb_frame.dirty)
                    next_state = WB0;
                else if (&scan)
                    next_state = COUNT_WR;
                else
                    next_scan = scan + 1'b1;
            end
            COUNT_WR: begin
                mem_req.valid = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = `DC_COUNTER_ADDR;
                mem_req.wdata = hit_count;
                if (mem_rsp.done) begin
                    inv_all    = 1'b1;
                    next_state = DONE_ST;
                end
            end
            DONE_ST: begin
                next_state = DONE_ST;   // held until reset
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

/* logic/dcache_data.sv */
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_data (
    input  logic                    CLK,
    input  logic                    n_rst,
    input  logic [`DC_IDX_W-1:0]    rd_idx,
    output dcache_pkg::word_t [1:0] rd_words0,
    output dcache_pkg::word_t [1:0] rd_words1,
    input  logic                    we,
    input  logic                    we_way,
    input  logic                    we_blkoff,
    input  logic [`DC_IDX_W-1:0]    we_idx,
    input  dcache_pkg::word_t       wdata
);

    // one two-word block per set and way
    dcache_pkg::word_t [1:0] blocks [2][`DC_SETS];

    assign rd_words0 = blocks[0][rd_idx];
    assign rd_words1 = blocks[1][rd_idx];

    // fills, completions and write hits all share this one word port
    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `DC_SETS; s++) begin
                    blocks[w][s] <= '0;
                end
            end
        end else if (we) begin
            blocks[we_way][we_idx][we_blkoff] <= wdata;
        end
    end

endmodule

/* logic/dcache_pkg.sv */
`include "dcache_config.svh"

package dcache_pkg;

    typedef logic [31:0] word_t;

    // word address as seen by the cache
    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic [`DC_IDX_W-1:0] idx;
        logic                 blkoff;
        logic [1:0]           byteoff;
    } dc_addr_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
        word_t [1:0]          data;  // indexed by blkoff
    } dc_frame_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        word_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  hit;
        word_t rdata;
    } cpu_rsp_t;

    // single-word request between the controller and the bus master
    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        word_t adr;
        word_t dat_o;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        word_t dat_i;
    } wb_s2m_t;

endpackage

/* logic/dcache_tags.sv */
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_tags (
    input  logic                 CLK,
    input  logic                 n_rst,
    input  logic [`DC_IDX_W-1:0] idx,
    input  logic [`DC_TAG_W-1:0] tag,
    input  logic                 touch,
    input  logic                 touch_way,
    input  logic                 fill,
    input  logic                 fill_way,
    input  logic                 set_dirty,
    input  logic                 clear_dirty,
    input  logic                 inv_all,
    output logic                 hit_way0,
    output logic                 hit_way1,
    output logic                 victim_way,
    output logic                 victim_dirty,
    output logic [`DC_TAG_W-1:0] victim_tag,
    input  logic [`DC_IDX_W-1:0] scan_idx,
    output logic                 scan_dirty0,
    output logic                 scan_dirty1,
    output logic [`DC_TAG_W-1:0] scan_tag0,
    output logic [`DC_TAG_W-1:0] scan_tag1
);

    logic [1:0][`DC_SETS-1:0] valid;
    logic [1:0][`DC_SETS-1:0] dirty;
    logic [`DC_SETS-1:0]      lru;   // way to replace next in each set
    logic [`DC_TAG_W-1:0]     tags [2][`DC_SETS];

    //////////////////////////////////////////////////
    // look-up and victim selection
    //////////////////////////////////////////////////

    assign hit_way0 = valid[0][idx] && (tags[0][idx] == tag);
    assign hit_way1 = valid[1][idx] && (tags[1][idx] == tag);

    assign victim_way   = lru[idx];
    assign victim_dirty = valid[victim_way][idx] && dirty[victim_way][idx];
    assign victim_tag   = tags[victim_way][idx];

    // flush side, walks the sets independently of the processor address
    assign scan_dirty0 = valid[0][scan_idx] && dirty[0][scan_idx];
    assign scan_dirty1 = valid[1][scan_idx] && dirty[1][scan_idx];
    assign scan_tag0   = tags[0][scan_idx];
    assign scan_tag1   = tags[1][scan_idx];

    //////////////////////////////////////////////////
    // state updates
    //////////////////////////////////////////////////

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            valid <= '0;
            dirty <= '0;
            lru   <= '0;
        end else if (inv_all) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            if (fill) begin
                valid[fill_way][idx] <= 1'b1;
                dirty[fill_way][idx] <= 1'b0;   // fresh block matches memory
            end
            if (set_dirty)
                dirty[touch_way][idx] <= 1'b1;
            if (clear_dirty)
                dirty[fill_way][scan_idx] <= 1'b0;
            if (touch)
                lru[idx] <= ~touch_way;  // the other way becomes the victim
        end
    end

    always_ff @(posedge CLK) begin
        if (fill)
            tags[fill_way][idx] <= tag;
    end

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/100ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                 CLK,
    input  logic                 n_rst,
    input  logic                 halt,
    input  dcache_pkg::cpu_req_t req,
    output dcache_pkg::cpu_rsp_t rsp,
    output logic                 done,
    output dcache_pkg::wb_m2s_t  wb_o,
    input  dcache_pkg::wb_s2m_t  wb_i
);

    //////////////////////////////////////////////////
    // internal wiring
    //////////////////////////////////////////////////

    dcache_pkg::mem_req_t    mem_req;
    dcache_pkg::mem_rsp_t    mem_rsp;
    logic [`DC_IDX_W-1:0]    idx, scan_idx, rd_idx, we_idx;
    logic [`DC_TAG_W-1:0]    tag, victim_tag, scan_tag0, scan_tag1;
    logic                    touch, touch_way, fill, fill_way;
    logic                    set_dirty, clear_dirty, inv_all;
    logic                    hit_way0, hit_way1, victim_way, victim_dirty;
    logic                    scan_dirty0, scan_dirty1;
    dcache_pkg::word_t [1:0] rd_words0, rd_words1;
    logic                    we, we_way, we_blkoff;
    dcache_pkg::word_t       wdata;

    // port names match the wires one to one
    dcache_tags i_tags (.*);

    dcache_data i_data (.*);

    dcache_ctrl i_ctrl (.*);

    wb_master i_wb_master (.*);

endmodule

/* logic/wb_master.sv */
`timescale 1ns/100ps

module wb_master (
    input  logic                 CLK,
    input  logic                 n_rst,
    input  dcache_pkg::mem_req_t mem_req,
    output dcache_pkg::mem_rsp_t mem_rsp,
    output dcache_pkg::wb_m2s_t  wb_o,
    input  dcache_pkg::wb_s2m_t  wb_i
);

    logic              cyc_q;
    logic              ack_q;   // high in the cycle after an ack
    logic              we_q;
    dcache_pkg::word_t adr_q;
    dcache_pkg::word_t dat_q;

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            cyc_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= cyc_q && wb_i.ack;
            if (cyc_q && wb_i.ack)
                cyc_q <= 1'b0;
            else if (!cyc_q && !ack_q && mem_req.valid)
                cyc_q <= 1'b1;
        end
    end

    // request is captured when the cycle opens
    always_ff @(posedge CLK) begin
        if (!cyc_q && !ack_q && mem_req.valid) begin
            we_q  <= mem_req.we;
            adr_q <= mem_req.addr;
            dat_q <= mem_req.wdata;
        end
    end

    assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat_o: dat_q};

    assign mem_rsp.done  = cyc_q && wb_i.ack;  // combinational in the ack cycle
    assign mem_rsp.rdata = wb_i.dat_i;

endmodule

/* test/tb_dcache.sv */
`timescale 1ns/100ps
`include "dcache_config.svh"

module tb_dcache;

    localparam int          N_DIRECTED = 13;
    localparam int          N_RANDOM   = 300;
    localparam int          LIMIT      = 5 + 40 * (N_DIRECTED + N_RANDOM) + 2000;
    localparam int          SAMPLE     = 5;   // lands in the low phase after the falling-edge drive
    localparam int          AW         = $clog2(`DC_MEM_WORDS);
    localparam int          COUNT_WIDX = `DC_COUNTER_ADDR >> 2;
    localparam logic [31:0] SEED       = 32'h0eae_2b52;

    logic                 CLK;
    logic                 n_rst;
    logic                 halt;
    dcache_pkg::cpu_req_t req;
    dcache_pkg::cpu_rsp_t rsp;
    logic                 done;
    dcache_pkg::wb_m2s_t  wb_o;
    dcache_pkg::wb_s2m_t  wb_i;

    integer               seed;
    int                   cycles = 0;
    dcache_pkg::word_t    shadow [`DC_MEM_WORDS];
    logic                 m_valid [2][`DC_SETS];
    logic [`DC_TAG_W-1:0] m_tag [2][`DC_SETS];
    logic                 m_lru [`DC_SETS];   // way to replace next
    dcache_pkg::word_t    m_hits;
    dcache_pkg::word_t    exp_q [$];
    string                name_q [$];

    dcache_top i_dcache_top (
        .CLK, .n_rst, .halt, .req, .rsp, .done, .wb_o, .wb_i
    );

    tb_wb_memory #(.SEED(SEED)) i_wb_memory (.CLK, .n_rst, .m2s(wb_o), .s2m(wb_i));

    initial CLK = 1'b0;
    always #10 CLK = ~CLK;

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////

    // models a two-way LRU write-allocate cache and returns the word before a write
    function automatic dcache_pkg::word_t predict_access(input logic wr,
                                                         input dcache_pkg::word_t addr,
                                                         input dcache_pkg::word_t wdata);
        dcache_pkg::dc_addr_t a;
        logic                 way;
        logic                 hit;
        dcache_pkg::word_t    old;
        a   = dcache_pkg::dc_addr_t'(addr);
        hit = 1'b0;
        way = m_lru[a.idx];
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][a.idx] && m_tag[w][a.idx] == a.tag) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        if (hit) begin
            m_hits = m_hits + 32'd1;
        end else begin
            m_valid[way][a.idx] = 1'b1;
            m_tag[way][a.idx]   = a.tag;
        end
        m_lru[a.idx] = ~way;
        old = shadow[addr[AW+1:2]];
        if (wr)
            shadow[addr[AW+1:2]] = wdata;
        return old;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_rdata(input string test, input dcache_pkg::word_t exp,
                                 input dcache_pkg::word_t act);
        if (act !== exp)
            report_error($sformatf("FAILED %s: expected %h, actual %h", test, exp, act));
    endtask

    task automatic compare_mem(input string test, input int widx,
                               input dcache_pkg::word_t exp, input dcache_pkg::word_t act);
        if (act !== exp)
            report_error($sformatf("FAILED %s at word 0x%0h: expected %h, actual %h",
                                   test, widx, exp, act));
    endtask

    task automatic compare_count(input string test, input dcache_pkg::word_t exp,
                                 input dcache_pkg::word_t act);
        if (act !== exp)
            report_error($sformatf("FAILED %s: expected %0d, actual %0d", test, exp, act));
    endtask

    // holds the request until hit, then frees the bus at the next falling edge
    task automatic cpu_access(input string test, input logic wr,
                              input dcache_pkg::word_t addr, input dcache_pkg::word_t wdata);
        dcache_pkg::word_t exp;
        exp = predict_access(wr, addr, wdata);
        if (!wr) begin
            exp_q.push_back(exp);
            name_q.push_back(test);
        end
        req = '{rd: !wr, wr: wr, addr: addr, wdata: wdata};
        #(SAMPLE);
        while (!rsp.hit) begin
            @(negedge CLK);
            #(SAMPLE);
        end
        @(negedge CLK);
        req = '0;
    endtask

    // read data is checked here, in the cycle that carries hit
    always @(negedge CLK) begin
        #(SAMPLE);
        if (n_rst && rsp.hit && req.rd) begin
            if (exp_q.size() == 0)
                report_error("the cache answered a read that nobody was waiting for");
            else
                compare_rdata(name_q.pop_front(), exp_q.pop_front(), rsp.rdata);
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT)
            report_error($sformatf("timeout, the run did not finish in %0d cycles", LIMIT));
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        int                gap;
        logic              wr;
        dcache_pkg::word_t addr;
        dcache_pkg::word_t data;
        seed   = SEED;
        n_rst  = 1'b0;
        halt   = 1'b0;
        req    = '0;
        m_hits = '0;
        for (int s = 0; s < `DC_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_tag[0][s]   = '0;
            m_tag[1][s]   = '0;
            m_lru[s]      = 1'b0;
        end
        repeat (5) @(negedge CLK);
        n_rst = 1'b1;
        for (int i = 0; i < `DC_MEM_WORDS; i++) begin
            shadow[i] = i_wb_memory.mem[i];   // memory holds its reset pattern now
        end

        cpu_access("cold_read", 1'b0, 32'h0000_0040, '0);
        cpu_access("cold_read", 1'b0, 32'h0000_0104, '0);
        cpu_access("write_read", 1'b1, 32'h0000_0200, 32'h1111_2222);
        cpu_access("write_read", 1'b0, 32'h0000_0200, '0);
        cpu_access("write_read", 1'b1, 32'h0000_0204, 32'h3333_4444);
        cpu_access("write_read", 1'b0, 32'h0000_0204, '0);

        // three tags share set 5 so the third write pushes out a dirty block
        cpu_access("evict", 1'b1, 32'h0000_0028, 32'haaaa_0001);
        cpu_access("evict", 1'b1, 32'h0000_00ac, 32'hbbbb_0002);
        cpu_access("evict", 1'b1, 32'h0000_0128, 32'hcccc_0003);
        cpu_access("evict", 1'b0, 32'h0000_0028, '0);
        cpu_access("evict", 1'b0, 32'h0000_00ac, '0);
        cpu_access("evict", 1'b0, 32'h0000_0128, '0);
        cpu_access("evict", 1'b0, 32'h0000_00a8, '0);

        for (int n = 0; n < N_RANDOM; n++) begin
            wr   = 1'($random(seed));
            addr = $random(seed);
            if ($random(seed) & 1)
                addr = addr & 32'h0000_01fc;   // only four tags per set give plenty of hits
            else
                addr = addr & 32'h0000_07fc;
            data = $random(seed);
            cpu_access("random", wr, addr, wr ? data : '0);
            gap = $random(seed) & 3;
            repeat (gap) @(negedge CLK);
        end

        halt = 1'b1;
        #(SAMPLE);
        while (!done) begin
            @(negedge CLK);
            #(SAMPLE);
        end
        @(negedge CLK);
        halt = 1'b0;
        repeat (16) begin
            @(negedge CLK);
            if (wb_o.cyc || !done)
                report_error("the bus or done moved after the flush had finished");
        end
        if (exp_q.size() != 0)
            report_error("some reads never got an answer");

        $display("first-try hits predicted: %0d", m_hits);
        for (int i = 0; i < `DC_MEM_WORDS; i++) begin
            if (i == COUNT_WIDX)
                compare_count("hit_count", m_hits, i_wb_memory.mem[i]);
            else
                compare_mem("flush", i, shadow[i], i_wb_memory.mem[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* test/tb_wb_memory.sv */
`timescale 1ns/100ps
`include "dcache_config.svh"

module tb_wb_memory #(
    parameter logic [31:0] SEED = 32'h0eae_2b52
) (
    input  logic                CLK,
    input  logic                n_rst,
    input  dcache_pkg::wb_m2s_t m2s,
    output dcache_pkg::wb_s2m_t s2m
);

    localparam int AW = $clog2(`DC_MEM_WORDS);

    dcache_pkg::word_t mem [`DC_MEM_WORDS];
    logic [1:0]        waits;   // wait states left before the next ack
    integer            seed;
    logic [AW-1:0]     widx;

    // every word gets a value tied to its full address
    function automatic dcache_pkg::word_t fill_word(input int i);
        return (32'(i) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    initial seed = SEED;

    assign widx = m2s.adr[AW+1:2];

    always @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < `DC_MEM_WORDS; i++) begin
                mem[i] <= fill_word(i);
            end
            s2m.ack   <= 1'b0;
            s2m.dat_i <= '0;
            waits     <= 2'd0;
        end else begin
            s2m.ack <= 1'b0;   // ack lasts one cycle, the master drops cyc with it
            if (m2s.cyc && m2s.stb && !s2m.ack) begin
                if (waits != 2'd0) begin
                    waits <= waits - 2'd1;
                end else begin
                    s2m.ack   <= 1'b1;
                    s2m.dat_i <= mem[widx];
                    if (m2s.we)
                        mem[widx] <= m2s.dat_o;
                    waits <= 2'($random(seed));   // stretch for the next bus cycle
                end
            end
        end
    end

endmodule
